/* verilog/cpu_types_pkg.sv */
// shared types for the fetch side
// word type, cache address split, memory depth
// opcode enum and the two-view instruction union
package cpu_types_pkg;

  // data and address word
  typedef logic [31:0] word_t;

  // cache geometry, fixed by the address split
  localparam int ICACHE_SETS = 16;
  // index is address bits 5 to 2
  localparam int IIDX_W = 4;
  // tag is address bits 31 to 6
  localparam int ITAG_W = 26;

  // backing memory depth in words
  localparam int RAM_WORDS = 1024;

  // address as seen by the instruction cache
  typedef struct packed {
    logic [ITAG_W-1:0] tag;
    logic [IIDX_W-1:0] idx;
    // always zero for word fetches
    logic [1:0]        boff;
  } icache_addr_t;

  // only the jump is decoded at fetch
  typedef enum logic [5:0] {
    OP_J     = 6'h02,
    // stands in for every non-jump opcode
    OP_OTHER = 6'h3f
  } opcode_t;

  // immediate format
  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } itype_t;

  // jump format
  typedef struct packed {
    opcode_t     opcode;
    // word target, low two bits implied
    logic [25:0] target;
  } jtype_t;

  // one instruction word, two ways to read it
  // opcode sits in the same bits in both views
  typedef union packed {
    itype_t itype;
    jtype_t jtype;
  } instr_u;

endpackage

/* verilog/datapath_cache_if.sv */
// fetch unit to instruction cache link
// read enable and address out, hit and data back
`timescale 1ns/1ps

interface datapath_cache_if;

  // level, held while the fetch waits
  logic imemREN;
  // combinational from imemaddr
  logic ihit;
  // held until ihit is seen at an edge
  cpu_types_pkg::word_t imemaddr;
  // cached word at imemaddr
  cpu_types_pkg::word_t imemload;

  // fetch side
  modport datapath (
    output imemREN, imemaddr,
    input  ihit, imemload
  );

  // cache side
  modport cache (
    input  imemREN, imemaddr,
    output ihit, imemload
  );

endinterface

/* verilog/caches_if.sv */
// instruction cache to memory link
// fill request out, wait level and word back
`timescale 1ns/1ps

interface caches_if;

  // high for the whole fill
  logic iREN;
  // memory still busy
  logic iwait;
  // stable while iREN is high
  cpu_types_pkg::word_t iaddr;
  // valid once iwait drops
  cpu_types_pkg::word_t iload;

  // cache side
  modport cache (
    output iREN, iaddr,
    input  iwait, iload
  );

  // memory side
  modport mem (
    input  iREN, iaddr,
    output iwait, iload
  );

endinterface

/* verilog/icache.sv */
// direct-mapped instruction cache, 16 one-word blocks
// tag, valid and data arrays with a combinational hit
// IDLE/REQUEST/LOAD miss controller
`timescale 1ns/1ps

module icache (
  input logic             CLK,
  input logic             nRST,
  datapath_cache_if.cache dcif,
  caches_if.cache         cif
);

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    REQUEST = 2'd1,
    LOAD    = 2'd2
  } state_t;

  state_t state_q;
  state_t state_d;

  // fetch address split into tag and index
  cpu_types_pkg::icache_addr_t req_addr;

  // block storage
  cpu_types_pkg::word_t             data_mem [cpu_types_pkg::ICACHE_SETS];
  logic [cpu_types_pkg::ITAG_W-1:0] tag_mem  [cpu_types_pkg::ICACHE_SETS];
  logic [cpu_types_pkg::ICACHE_SETS-1:0] valid_q;

  // block write strobe, only in LOAD
  logic wen;
  logic tag_match;

  assign req_addr = dcif.imemaddr;

  // valid block with matching tag at this index
  assign tag_match = valid_q[req_addr.idx] &&
                     (tag_mem[req_addr.idx] == req_addr.tag);

  // no hit while the block is being written
  assign dcif.ihit     = tag_match && !wen;
  assign dcif.imemload = data_mem[req_addr.idx];

  // fill address is the fetch address itself
  assign cif.iaddr = dcif.imemaddr;

  // controller next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // read without a matching block starts a fill
        if (dcif.imemREN && !tag_match) begin
          state_d = REQUEST;
        end
      end
      REQUEST: begin
        // hold until memory stops waiting
        if (!cif.iwait) begin
          state_d = LOAD;
        end
      end
      LOAD: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // controller outputs
  always_comb begin
    cif.iREN = (state_q == REQUEST) || (state_q == LOAD);
    wen      = (state_q == LOAD);
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // valid bits cleared on reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
    end else if (wen) begin
      valid_q[req_addr.idx] <= 1'b1;
    end
  end

  // data and tag written together in LOAD
  always_ff @(posedge CLK) begin
    if (wen) begin
      data_mem[req_addr.idx] <= cif.iload;
      tag_mem[req_addr.idx]  <= req_addr.tag;
    end
  end

  // memory must have finished before the block is written
  a_load_no_wait : assert property (
    @(posedge CLK) disable iff (!nRST)
    (state_q == LOAD) |-> !cif.iwait
  );

  // fetch address held through the fill
  a_req_addr_stable : assert property (
    @(posedge CLK) disable iff (!nRST)
    (state_q == REQUEST) |=> $stable(dcif.imemaddr)
  );

endmodule

/* verilog/fetch_unit.sv */
// program counter and next-PC logic
// follows unconditional jumps, passes the fetched word out
`timescale 1ns/1ps

module fetch_unit #(
  parameter cpu_types_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      run,
  datapath_cache_if.datapath        dcif,
  output logic                      instr_valid,
  output cpu_types_pkg::word_t      instr,
  output cpu_types_pkg::word_t      instr_pc
);

  cpu_types_pkg::word_t pc_q;
  cpu_types_pkg::word_t pc_next;

  // fetched word, decoded just far enough for jumps
  cpu_types_pkg::instr_u fetched;

  // PC moves only on a hit while running
  logic advance;

  assign fetched = dcif.imemload;
  assign advance = run && dcif.ihit;

  // request follows run, address is the PC
  assign dcif.imemREN  = run;
  assign dcif.imemaddr = pc_q;

  // instruction out in the same cycle as the hit
  assign instr       = dcif.imemload;
  assign instr_pc    = pc_q;
  assign instr_valid = advance;

  // jump keeps the top four PC bits
  always_comb begin
    if (fetched.itype.opcode == cpu_types_pkg::OP_J) begin
      pc_next = {pc_q[31:28], fetched.jtype.target, 2'b00};
    end else begin
      pc_next = pc_q + 32'd4;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc_q <= RESET_PC;
    end else if (advance) begin
      pc_q <= pc_next;
    end
  end

  // RESET_PC and jump targets keep word alignment
  a_pc_aligned : assert property (
    @(posedge CLK) disable iff (!nRST)
    pc_q[1:0] == 2'b00
  );

endmodule

/* verilog/instr_ram.sv */
// word-addressed instruction memory
// request counter for wait cycles, program-load write port
`timescale 1ns/1ps

module instr_ram #(
  parameter int RAM_LATENCY = 2
) (
  input  logic                                          CLK,
  input  logic                                          nRST,
  caches_if.mem                                         cif,
  input  logic                                          prog_wen,
  input  logic [$clog2(cpu_types_pkg::RAM_WORDS)-1:0]   prog_addr,
  input  cpu_types_pkg::word_t                          prog_data
);

  // word index width, 10 bits for 1024 words
  localparam int RAM_AW = $clog2(cpu_types_pkg::RAM_WORDS);
  // counter wide enough to reach the latency
  localparam int CNT_W = (RAM_LATENCY > 0) ? $clog2(RAM_LATENCY + 1) : 1;

  cpu_types_pkg::word_t mem [cpu_types_pkg::RAM_WORDS];

  // iaddr bits 11 to 2, higher bits wrap
  logic [RAM_AW-1:0] rd_idx;

  // wait cycles spent on the current request
  logic [CNT_W-1:0] wait_cnt;
  logic             cnt_done;

  assign rd_idx = cif.iaddr[RAM_AW+1:2];

  // zero latency is done from the start
  assign cnt_done = (wait_cnt >= CNT_W'(RAM_LATENCY));

  // busy while a request is open and the count is short
  assign cif.iwait = cif.iREN && !cnt_done;

  // read is combinational, taken once iwait drops
  assign cif.iload = mem[rd_idx];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (!cif.iREN) begin
      // request over, ready for the next one
      wait_cnt <= '0;
    end else if (!cnt_done) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // program load, one word per cycle
  always_ff @(posedge CLK) begin
    if (prog_wen) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // loading and fetching never overlap
  a_no_load_during_fetch : assert property (
    @(posedge CLK) disable iff (!nRST)
    !(prog_wen && cif.iREN)
  );

endmodule

/* verilog/fetch_top.sv */
// fetch side top level
// fetch unit, instruction cache and memory joined by two interfaces
`timescale 1ns/1ps

module fetch_top #(
  parameter int                   RAM_LATENCY = 2,
  parameter cpu_types_pkg::word_t RESET_PC    = 32'h0000_0000
) (
  input  logic                                        CLK,
  input  logic                                        nRST,
  input  logic                                        run,
  input  logic                                        prog_wen,
  input  logic [$clog2(cpu_types_pkg::RAM_WORDS)-1:0] prog_addr,
  input  cpu_types_pkg::word_t                        prog_data,
  output logic                                        instr_valid,
  output cpu_types_pkg::word_t                        instr,
  output cpu_types_pkg::word_t                        instr_pc
);

  // fetch to cache
  datapath_cache_if dcif ();
  // cache to memory
  caches_if cif ();

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) fetch_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .run         (run),
    .dcif        (dcif.datapath),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc)
  );

  icache icache_i (
    .CLK  (CLK),
    .nRST (nRST),
    .dcif (dcif.cache),
    .cif  (cif.cache)
  );

  instr_ram #(
    .RAM_LATENCY (RAM_LATENCY)
  ) ram_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .cif       (cif.mem),
    .prog_wen  (prog_wen),
    .prog_addr (prog_addr),
    .prog_data (prog_data)
  );

endmodule

/* verification/fetch_tb.sv */
// testbench for the fetch side
// program loading, resets with fetch requested, xorshift run toggling, reference model
// concurrent assertions check the fetched stream against the model
`timescale 1ns/1ps

module fetch_tb;

  localparam int RAM_LATENCY = 3;
  localparam cpu_types_pkg::word_t RESET_PC = 32'h0000_0000;
  localparam logic [31:0] SEED = 32'ha9a3;

  // program layout, loop B aliases the indices of loop A
  localparam int LOOP_A_LEN = 12;
  localparam int LOOP_B_LEN = 10;
  localparam cpu_types_pkg::word_t LOOP_A_BASE = RESET_PC;
  localparam cpu_types_pkg::word_t LOOP_B_BASE = RESET_PC + 32'h40;
  // loop B jumps back into loop A here
  localparam cpu_types_pkg::word_t REENTRY_PC = RESET_PC + 32'h08;

  // timeout budget per expected fetch
  localparam int CYCLES_PER_FETCH = 24;

  logic                 CLK;
  logic                 nRST;
  logic                 run;
  logic                 prog_wen;
  logic [9:0]           prog_addr;
  cpu_types_pkg::word_t prog_data;
  logic                 instr_valid;
  cpu_types_pkg::word_t instr;
  cpu_types_pkg::word_t instr_pc;

  // reference model state
  cpu_types_pkg::word_t             model_mem [cpu_types_pkg::RAM_WORDS];
  cpu_types_pkg::word_t             exp_pc;
  cpu_types_pkg::icache_addr_t      exp_split;
  cpu_types_pkg::word_t             exp_word;
  cpu_types_pkg::word_t             model_word;
  logic [cpu_types_pkg::ICACHE_SETS-1:0] model_valid;
  logic [cpu_types_pkg::ITAG_W-1:0] model_tag [cpu_types_pkg::ICACHE_SETS];
  logic                             model_hit;
  logic                             seen_valid;
  int                               fetch_count;
  int                               streak;
  int                               max_streak;

  // stimulus state
  logic [31:0] rng;
  int          hold_cnt;

  fetch_top #(
    .RAM_LATENCY (RAM_LATENCY),
    .RESET_PC    (RESET_PC)
  ) dut_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .run         (run),
    .prog_wen    (prog_wen),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc)
  );

  always #20 CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // jump keeps PC[31:28], target fills the rest, word aligned
  function automatic cpu_types_pkg::word_t follow_pc(input cpu_types_pkg::word_t pc,
                                                     input cpu_types_pkg::word_t w);
    if (w[31:26] == 6'h02) begin
      return {pc[31:28], w[25:0], 2'b00};
    end
    return pc + 32'd4;
  endfunction

  function automatic cpu_types_pkg::word_t jump_word(input cpu_types_pkg::word_t target);
    cpu_types_pkg::instr_u w;
    w = '0;
    w.jtype.opcode = cpu_types_pkg::OP_J;
    w.jtype.target = target[27:2];
    return w;
  endfunction

  // random word that never decodes as a jump
  function automatic cpu_types_pkg::word_t plain_word(input logic [31:0] r);
    cpu_types_pkg::word_t w;
    w = r;
    if (w[31:26] == 6'h02) begin
      w[31:26] = 6'h03;
    end
    return w;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  // run level held through reset and the first cycle after it
  task automatic apply_reset(input logic run_level);
    @(negedge CLK);
    run  = run_level;
    nRST = 1'b0;
    repeat (8) @(negedge CLK);
    nRST = 1'b1;
  endtask

  // one word through the program port, mirrored in the model
  task automatic write_word(input cpu_types_pkg::word_t addr, input cpu_types_pkg::word_t data);
    @(negedge CLK);
    prog_wen  = 1'b1;
    prog_addr = addr[11:2];
    prog_data = data;
    model_mem[addr[11:2]] = data;
  endtask

  // random body, last word jumps to target
  task automatic load_loop(input cpu_types_pkg::word_t base, input int len,
                           input cpu_types_pkg::word_t target);
    for (int i = 0; i < len - 1; i++) begin
      rng = xorshift32(rng);
      write_word(base + 32'(4 * i), plain_word(rng));
    end
    write_word(base + 32'(4 * (len - 1)), jump_word(target));
  endtask

  task automatic end_load();
    @(negedge CLK);
    prog_wen = 1'b0;
  endtask

  // steady high, or mostly high with random low windows
  task automatic drive_run(input bit random_run);
    rng = xorshift32(rng);
    if (!random_run) begin
      run = 1'b1;
    end else if (hold_cnt > 0) begin
      hold_cnt--;
      run = 1'b0;
    end else if (rng[3:0] == 4'h0) begin
      hold_cnt = int'(rng[6:4]);
      run = 1'b0;
    end else begin
      run = 1'b1;
    end
  endtask

  // keep fetching until n more instructions were seen
  task automatic run_fetches(input int n, input bit random_run, input string what);
    int target;
    int cycles;
    target = fetch_count + n;
    cycles = 0;
    @(negedge CLK);
    while (fetch_count < target) begin
      if (cycles > n * CYCLES_PER_FETCH) begin
        stop_with_failure($sformatf("Timeout: %s did not reach %0d fetches", what, n));
      end
      drive_run(random_run);
      cycles++;
      @(negedge CLK);
    end
    run = 1'b0;
  endtask

  assign exp_split  = exp_pc;
  assign exp_word   = model_mem[exp_pc[11:2]];
  assign model_word = model_mem[instr_pc[11:2]];
  // model cache holds the block the model expects next
  assign model_hit  = model_valid[exp_split.idx] &&
                      (model_tag[exp_split.idx] == exp_split.tag);

  // model follows every reported instruction
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      exp_pc      <= RESET_PC;
      seen_valid  <= 1'b0;
      model_valid <= '0;
      fetch_count <= 0;
      streak      <= 0;
    end else if (instr_valid) begin
      exp_pc                     <= follow_pc(exp_pc, exp_word);
      seen_valid                 <= 1'b1;
      model_valid[exp_split.idx] <= 1'b1;
      model_tag[exp_split.idx]   <= exp_split.tag;
      fetch_count                <= fetch_count + 1;
      streak                     <= streak + 1;
      if (streak + 1 > max_streak) begin
        max_streak <= streak + 1;
      end
    end else begin
      streak <= 0;
    end
  end

  a_reset_quiet : assert property (@(posedge CLK) !nRST |-> !instr_valid)
    else stop_with_failure($sformatf("Mismatch instr_valid in reset: got %h, expected 0",
                                     $sampled(instr_valid)));

  a_first_cycle : assert property (@(posedge CLK) $rose(nRST) |-> !instr_valid)
    else stop_with_failure($sformatf("Mismatch instr_valid after reset: got %h, expected 0",
                                     $sampled(instr_valid)));

  a_first_pc : assert property (@(posedge CLK) disable iff (!nRST)
    instr_valid && !seen_valid |-> instr_pc == RESET_PC)
    else stop_with_failure($sformatf("Mismatch first instr_pc: got %h, expected %h",
                                     $sampled(instr_pc), RESET_PC));

  a_instr_word : assert property (@(posedge CLK) disable iff (!nRST)
    instr_valid |-> instr == model_word)
    else stop_with_failure($sformatf("Mismatch instr at pc %h: got %h, expected %h",
                                     $sampled(instr_pc), $sampled(instr),
                                     $sampled(model_word)));

  a_pc_stream : assert property (@(posedge CLK) disable iff (!nRST)
    instr_valid |-> instr_pc == exp_pc)
    else stop_with_failure($sformatf("Mismatch instr_pc: got %h, expected %h",
                                     $sampled(instr_pc), $sampled(exp_pc)));

  a_run_hold : assert property (@(posedge CLK) disable iff (!nRST) !run |-> !instr_valid)
    else stop_with_failure($sformatf("Mismatch instr_valid with run low: got %h, expected 0",
                                     $sampled(instr_valid)));

  // cached block must hit in the same cycle
  a_cache_reuse : assert property (@(posedge CLK) disable iff (!nRST)
    run && model_hit |-> instr_valid)
    else stop_with_failure($sformatf("Mismatch instr_valid on cached pc %h: got %h, expected 1",
                                     $sampled(exp_pc), $sampled(instr_valid)));

  initial begin
    CLK       = 1'b0;
    nRST      = 1'b0;
    run       = 1'b0;
    prog_wen  = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    rng       = SEED;
    hold_cnt  = 0;

    // single loop, warm up then run from the cache
    apply_reset(1'b0);
    load_loop(LOOP_A_BASE, LOOP_A_LEN, LOOP_A_BASE);
    end_load();
    run_fetches(4 * LOOP_A_LEN, 1'b1, "warm-up of loop A");
    run_fetches(4 * LOOP_A_LEN, 1'b0, "steady run of loop A");
    a_hit_streak : assert (max_streak >= 2 * LOOP_A_LEN)
      else stop_with_failure($sformatf("cached loop gave only %0d back-to-back fetches",
                                       max_streak));

    // two loops fighting over the same indices
    // new program written over the warm cache, reset clears it with fetch requested
    load_loop(LOOP_A_BASE, LOOP_A_LEN, LOOP_B_BASE);
    load_loop(LOOP_B_BASE, LOOP_B_LEN, REENTRY_PC);
    end_load();
    apply_reset(1'b1);
    run_fetches(120, 1'b1, "aliased loops with random run");
    run_fetches(40, 1'b0, "aliased loops with steady run");

    $display("All tests passed");
    $finish;
  end

endmodule

/* sources.f */
verilog/cpu_types_pkg.sv
verilog/datapath_cache_if.sv
verilog/caches_if.sv
verilog/icache.sv
verilog/fetch_unit.sv
verilog/instr_ram.sv
verilog/fetch_top.sv
verification/fetch_tb.sv

/* Makefile */
# Verilator build and run of the fetch testbench
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
SIM_ARGS  ?=

.PHONY: sim clean

# a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) --binary --assert --top-module $(TOP) --Mdir $(OBJ_DIR) \
		-f $(FILELIST) $(VFLAGS)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
